// ==== common/flash_if.sv ====
// one decoded scene write, assembler to scene config
interface flash_if
  import rtx_pkg::*;
();

  // single cycle write strobe
  logic           wen;

  // target, idx and payload only mean something while wen is high
  flash_target_t  target;
  obj_idx_t       idx;
  flash_payload_t payload;

  // level, packet in flight from command byte up to its wen
  logic           active;

  modport assembler (
    output wen,
    output target,
    output idx,
    output payload,
    output active
  );

  // scene side
  modport cfg (
    input wen,
    input target,
    input idx,
    input payload,
    input active
  );

endinterface

// ==== common/rtx_pkg.sv ====
`include "rtx_settings.svh"

package rtx_pkg;

  // one signed Q12.12 number
  typedef logic signed [`RTX_FP_BITS-1:0] fp_t;

  // x in the top third, then y, then z
  typedef logic [3*`RTX_FP_BITS-1:0] vec3_t;

  // packed scene object as the tracer reads it
  typedef logic [63:0] obj_t;

  // object memory address
  typedef logic [$clog2(`RTX_MAX_NUM_OBJS)-1:0] obj_idx_t;

  // object count, needs room for the full depth itself
  typedef logic [$clog2(`RTX_MAX_NUM_OBJS+1)-1:0] obj_count_t;

  typedef logic [7:0] bounce_t;

  // what a decoded flash write updates
  typedef enum logic [2:0] {
    TGT_OBJ,
    TGT_CAM_ORIGIN,
    TGT_CAM_FORWARD,
    TGT_CAM_RIGHT,
    TGT_CAM_UP,
    TGT_NUM_OBJS,
    TGT_MAX_BOUNCES
  } flash_target_t;

  // widest payload is one vec3, shorter ones sit in the low bytes
  typedef logic [71:0] flash_payload_t;

  // uart byte receiver
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  // packet assembler
  typedef enum logic {
    ASM_IDLE,
    ASM_PAYLOAD
  } asm_state_t;

endpackage

// ==== common/rtx_settings.svh ====
`ifndef RTX_SETTINGS_SVH
`define RTX_SETTINGS_SVH

// clk_rtx cycles per uart bit
// 16 keeps simulation short, real line rates need far more
`define RTX_CLKS_PER_BIT 16

// idle bit times before an open packet is dropped
`define RTX_FLASH_TIMEOUT_BITS 64

// object memory depth
`define RTX_MAX_NUM_OBJS 32

// fixed point width, Q12.12 so one is 24'h001000
`define RTX_FP_BITS 24

// last pixel of a 720p frame
`define RTX_H_LAST 1279
`define RTX_V_LAST 719

`endif

// ==== design/rtx_flash_top.sv ====
module rtx_flash_top
  import rtx_pkg::*;
(
  input  logic        clk_rtx,
  input  logic        sys_rst,
  input  logic        uart_rxd,
  input  obj_idx_t    obj_rd_idx,
  input  logic        rtx_valid,
  input  logic [10:0] rtx_h_count,
  input  logic [9:0]  rtx_v_count,
  input  logic        force_redraw,
  output obj_t        obj,
  output vec3_t       cam_origin,
  output vec3_t       cam_forward,
  output vec3_t       cam_right,
  output vec3_t       cam_up,
  output obj_count_t  num_objs,
  output bounce_t     max_bounces,
  output logic        rtx_overwrite,
  output logic        flash_active
);

  logic       rx_valid;
  logic [7:0] rx_byte;

  // decoded write between assembler and scene registers
  flash_if flash ();

  // serial line to bytes
  uart_receive u_uart_receive (
    .clk_rtx  (clk_rtx),
    .sys_rst  (sys_rst),
    .uart_rxd (uart_rxd),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

  // bytes to packets
  uart_memflash_rtx u_memflash (
    .clk_rtx  (clk_rtx),
    .sys_rst  (sys_rst),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .flash    (flash.assembler)
  );

  // packets to scene state
  scene_config u_scene_config (
    .clk_rtx       (clk_rtx),
    .sys_rst       (sys_rst),
    .flash         (flash.cfg),
    .obj_rd_idx    (obj_rd_idx),
    .rtx_valid     (rtx_valid),
    .rtx_h_count   (rtx_h_count),
    .rtx_v_count   (rtx_v_count),
    .force_redraw  (force_redraw),
    .obj           (obj),
    .cam_origin    (cam_origin),
    .cam_forward   (cam_forward),
    .cam_right     (cam_right),
    .cam_up        (cam_up),
    .num_objs      (num_objs),
    .max_bounces   (max_bounces),
    .rtx_overwrite (rtx_overwrite)
  );

  // busy indicator for the board
  assign flash_active = flash.active;

endmodule

// ==== design/scene_config.sv ====
`include "rtx_settings.svh"

module scene_config
  import rtx_pkg::*;
(
  input  logic        clk_rtx,
  input  logic        sys_rst,
  flash_if.cfg        flash,
  input  obj_idx_t    obj_rd_idx,
  input  logic        rtx_valid,
  input  logic [10:0] rtx_h_count,
  input  logic [9:0]  rtx_v_count,
  input  logic        force_redraw,
  output obj_t        obj,
  output vec3_t       cam_origin,
  output vec3_t       cam_forward,
  output vec3_t       cam_right,
  output vec3_t       cam_up,
  output obj_count_t  num_objs,
  output bounce_t     max_bounces,
  output logic        rtx_overwrite
);

  // Q12.12, half the bits are fraction
  localparam int FRAC_BITS = `RTX_FP_BITS / 2;
  localparam fp_t FP_ZERO = '0;
  localparam fp_t FP_ONE = fp_t'(1 << FRAC_BITS);
  // forward length of half the screen width gives a 90 degree fov
  localparam fp_t FP_HALF_W = fp_t'(((`RTX_H_LAST + 1) / 2) << FRAC_BITS);
  localparam obj_count_t NUM_OBJS_MAX = obj_count_t'(`RTX_MAX_NUM_OBJS);
  localparam obj_count_t NUM_OBJS_RST = obj_count_t'(16);
  localparam bounce_t BOUNCES_RST = bounce_t'(3);

  obj_t obj_mem [`RTX_MAX_NUM_OBJS];
  logic scene_changed;
  logic frame_end;
  logic [7:0] pay_byte;

  // single byte writes use the low byte
  assign pay_byte = flash.payload[7:0];

  // camera, count and bounce limit
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      cam_origin  <= {FP_ZERO, FP_ZERO, FP_ZERO};
      cam_forward <= {FP_ZERO, FP_ZERO, FP_HALF_W};
      cam_right   <= {FP_ONE, FP_ZERO, FP_ZERO};
      cam_up      <= {FP_ZERO, FP_ONE, FP_ZERO};
      num_objs    <= NUM_OBJS_RST;
      max_bounces <= BOUNCES_RST;
    end else if (flash.wen) begin
      case (flash.target)
        TGT_CAM_ORIGIN:  cam_origin  <= flash.payload;
        TGT_CAM_FORWARD: cam_forward <= flash.payload;
        TGT_CAM_RIGHT:   cam_right   <= flash.payload;
        TGT_CAM_UP:      cam_up      <= flash.payload;
        TGT_NUM_OBJS: begin
          // tracer would walk off the end of memory otherwise
          if (pay_byte > 8'(`RTX_MAX_NUM_OBJS)) begin
            num_objs <= NUM_OBJS_MAX;
          end else begin
            num_objs <= obj_count_t'(pay_byte);
          end
        end
        TGT_MAX_BOUNCES: max_bounces <= pay_byte;
        default: ;
      endcase
    end
  end

  // object memory starts out empty
  initial begin
    for (int i = 0; i < `RTX_MAX_NUM_OBJS; i++) begin
      obj_mem[i] = '0;
    end
  end

  // one write port from flash, one registered read port for the tracer
  always_ff @(posedge clk_rtx) begin
    if (flash.wen && flash.target == TGT_OBJ) begin
      obj_mem[flash.idx] <= obj_t'(flash.payload[$bits(obj_t)-1:0]);
    end
    obj <= obj_mem[obj_rd_idx];
  end

  // last pixel of the frame just finished
  assign frame_end = rtx_valid
                     && (rtx_h_count == 11'(`RTX_H_LAST))
                     && (rtx_v_count == 10'(`RTX_V_LAST));

  // overwrite holds for the whole next frame
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      rtx_overwrite <= 1'b0;
      scene_changed <= 1'b0;
    end else if (frame_end) begin
      // a write landing on the last pixel counts for this frame
      rtx_overwrite <= force_redraw | scene_changed | flash.wen;
      scene_changed <= 1'b0;
    end else if (flash.wen) begin
      scene_changed <= 1'b1;
    end
  end

  // count stays inside the memory
  assert property (@(posedge clk_rtx) disable iff (sys_rst) num_objs <= NUM_OBJS_MAX);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_rtx_flash

verilator --binary --timing --assert -j 0 \
  -f sim.f \
  --top-module "$TOP" \
  -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Everything OK" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

// ==== sim.f ====
+incdir+common
common/rtx_pkg.sv
common/flash_if.sv
uart_flash/uart_receive.sv
uart_flash/uart_memflash_rtx.sv
design/scene_config.sv
design/rtx_flash_top.sv
tb/tb_rtx_flash.sv

// ==== tb/tb_rtx_flash.sv ====
`include "rtx_settings.svh"

module tb_rtx_flash
  import rtx_pkg::*;
();

  // close to twice the uart time of all tests together
  localparam int MAX_CYCLES = 40000;
  localparam int BIT_CLKS = `RTX_CLKS_PER_BIT;
  // abort window plus a few bit times of margin
  localparam int IDLE_LIMIT = (`RTX_FLASH_TIMEOUT_BITS + 8) * BIT_CLKS;

  logic clk_rtx;
  logic sys_rst;
  logic uart_rxd;
  obj_idx_t obj_rd_idx;
  logic rtx_valid;
  logic [10:0] rtx_h_count;
  logic [9:0] rtx_v_count;
  logic force_redraw;
  obj_t obj;
  vec3_t cam_origin;
  vec3_t cam_forward;
  vec3_t cam_right;
  vec3_t cam_up;
  obj_count_t num_objs;
  bounce_t max_bounces;
  logic rtx_overwrite;
  logic flash_active;

  // reference model of the scene state
  vec3_t exp_origin;
  vec3_t exp_forward;
  vec3_t exp_right;
  vec3_t exp_up;
  logic [7:0] exp_num;
  logic [7:0] exp_bounce;
  obj_t exp_mem [`RTX_MAX_NUM_OBJS];

  logic [31:0] lfsr;
  int cycle;
  int test_errs;
  int tests_passed;
  int tests_failed;

  rtx_flash_top uut (
    .clk_rtx       (clk_rtx),
    .sys_rst       (sys_rst),
    .uart_rxd      (uart_rxd),
    .obj_rd_idx    (obj_rd_idx),
    .rtx_valid     (rtx_valid),
    .rtx_h_count   (rtx_h_count),
    .rtx_v_count   (rtx_v_count),
    .force_redraw  (force_redraw),
    .obj           (obj),
    .cam_origin    (cam_origin),
    .cam_forward   (cam_forward),
    .cam_right     (cam_right),
    .cam_up        (cam_up),
    .num_objs      (num_objs),
    .max_bounces   (max_bounces),
    .rtx_overwrite (rtx_overwrite),
    .flash_active  (flash_active)
  );

  initial begin
    clk_rtx = 1'b0;
    forever #10 clk_rtx = ~clk_rtx;
  end

  // watchdog
  always @(posedge clk_rtx) begin
    cycle <= cycle + 1;
    if (cycle == MAX_CYCLES) begin
      $display("run stopped at the cycle limit, a test hung");
      $display("Something failed");
      $finish;
    end
  end

  // galois lfsr, x^32+x^22+x^2+x+1, one step per bit taken
  function automatic logic [71:0] take_bits(input int n);
    logic [71:0] bits;
    logic fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[0];
      lfsr = (lfsr >> 1) ^ (fb ? 32'h80200003 : 32'h0);
      bits = {bits[70:0], fb};
    end
    return bits;
  endfunction

  task automatic check_val(input string name, input logic [71:0] got, input logic [71:0] exp);
    assert (got === exp) else begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  // 8N1, lsb first, one idle bit after the stop bit
  task automatic send_byte(input logic [7:0] b);
    @(negedge clk_rtx);
    uart_rxd = 1'b0;
    repeat (BIT_CLKS) @(negedge clk_rtx);
    for (int i = 0; i < 8; i++) begin
      uart_rxd = b[i];
      repeat (BIT_CLKS) @(negedge clk_rtx);
    end
    uart_rxd = 1'b1;
    repeat (2 * BIT_CLKS) @(negedge clk_rtx);
  endtask

  // wait for the packet to close or be dropped
  task automatic wait_idle(output int waited);
    waited = 0;
    while (flash_active && waited < IDLE_LIMIT) begin
      @(negedge clk_rtx);
      waited++;
    end
    assert (!flash_active) else begin
      $display("flash_active stayed high after the packet");
      test_errs++;
    end
  endtask

  // command byte then payload msb first
  task automatic send_packet(input logic [7:0] cmd, input logic [71:0] pay, input int nbytes);
    int waited;
    send_byte(cmd);
    assert (flash_active) else begin
      $display("flash_active did not rise after command %h", cmd);
      test_errs++;
    end
    for (int i = nbytes - 1; i >= 0; i--) begin
      send_byte(pay[i*8 +: 8]);
    end
    wait_idle(waited);
  endtask

  task automatic check_scene();
    check_val("cam_origin", cam_origin, exp_origin);
    check_val("cam_forward", cam_forward, exp_forward);
    check_val("cam_right", cam_right, exp_right);
    check_val("cam_up", cam_up, exp_up);
    check_val("num_objs", 72'(num_objs), 72'(exp_num));
    check_val("max_bounces", 72'(max_bounces), 72'(exp_bounce));
  endtask

  // registered read, data one cycle after the address
  task automatic check_obj(input int idx);
    @(negedge clk_rtx);
    obj_rd_idx = obj_idx_t'(idx);
    @(negedge clk_rtx);
    check_val($sformatf("obj[%0d]", idx), 72'(obj), 72'(exp_mem[idx]));
  endtask

  // one last pixel strobe, overwrite sampled after it
  task automatic frame_strobe(input logic force_in, input logic exp_ow);
    @(negedge clk_rtx);
    rtx_valid = 1'b1;
    rtx_h_count = 11'(`RTX_H_LAST);
    rtx_v_count = 10'(`RTX_V_LAST);
    force_redraw = force_in;
    @(negedge clk_rtx);
    rtx_valid = 1'b0;
    force_redraw = 1'b0;
    check_val("rtx_overwrite", 72'(rtx_overwrite), 72'(exp_ow));
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic test_reset_defaults();
    // Q12.12, one is 0x001000 and 640 is 0x280000
    exp_origin = '0;
    exp_forward = {24'h000000, 24'h000000, 24'h280000};
    exp_right = {24'h001000, 24'h000000, 24'h000000};
    exp_up = {24'h000000, 24'h001000, 24'h000000};
    exp_num = 8'd16;
    exp_bounce = 8'd3;
    check_scene();
    check_val("rtx_overwrite", 72'(rtx_overwrite), 72'd0);
    check_val("flash_active", 72'(flash_active), 72'd0);
    finish_test("reset_defaults");
  endtask

  task automatic test_camera_writes();
    vec3_t v;
    for (int t = 0; t < 4; t++) begin
      v = take_bits(72);
      send_packet(8'h80 | 8'(t), v, 9);
      case (t)
        0: exp_origin = v;
        1: exp_forward = v;
        2: exp_right = v;
        default: exp_up = v;
      endcase
      check_scene();
      check_val("flash_active", 72'(flash_active), 72'd0);
    end
    finish_test("camera_writes");
  endtask

  task automatic test_count_bounce();
    logic [7:0] b;
    for (int t = 0; t < 3; t++) begin
      b = 8'(take_bits(8));
      send_packet(8'h85, 72'(b), 1);
      exp_bounce = b;
      check_scene();
    end
    // count is clamped to the memory depth
    send_packet(8'h84, 72'd40, 1);
    exp_num = 8'd32;
    check_scene();
    send_packet(8'h84, 72'd20, 1);
    exp_num = 8'd20;
    check_scene();
    finish_test("count_bounce");
  endtask

  task automatic test_object_memory();
    int idx_list [4];
    obj_t o;
    idx_list = '{0, 9, 22, 31};
    foreach (idx_list[i]) begin
      o = obj_t'(take_bits(64));
      send_packet(8'(idx_list[i]), 72'(o), 8);
      exp_mem[idx_list[i]] = o;
      check_obj(idx_list[i]);
    end
    // out of range index, bytes eaten but nothing written
    send_packet(8'd50, take_bits(64), 8);
    check_val("flash_active", 72'(flash_active), 72'd0);
    for (int i = 0; i < `RTX_MAX_NUM_OBJS; i++) begin
      check_obj(i);
    end
    finish_test("object_memory");
  endtask

  task automatic test_robustness();
    int waited;
    vec3_t v;
    // target 6 is unknown
    send_byte(8'h86);
    check_val("flash_active", 72'(flash_active), 72'd0);
    check_scene();
    // half a forward packet, then silence
    send_byte(8'h81);
    for (int i = 0; i < 4; i++) begin
      send_byte(8'(take_bits(8)));
    end
    check_val("flash_active", 72'(flash_active), 72'd1);
    wait_idle(waited);
    assert (waited >= (`RTX_FLASH_TIMEOUT_BITS - 2) * BIT_CLKS) else begin
      $display("open packet was dropped after only %0d cycles", waited);
      test_errs++;
    end
    check_scene();
    v = take_bits(72);
    send_packet(8'h81, v, 9);
    exp_forward = v;
    check_scene();
    finish_test("robustness");
  endtask

  task automatic test_overwrite_latch();
    // earlier tests left writes pending
    frame_strobe(1'b0, 1'b1);
    frame_strobe(1'b0, 1'b0);
    send_packet(8'h85, 72'd7, 1);
    exp_bounce = 8'd7;
    check_scene();
    frame_strobe(1'b0, 1'b1);
    frame_strobe(1'b0, 1'b0);
    frame_strobe(1'b1, 1'b1);
    frame_strobe(1'b0, 1'b0);
    finish_test("overwrite_latch");
  endtask

  initial begin
    sys_rst = 1'b1;
    uart_rxd = 1'b1;
    obj_rd_idx = '0;
    rtx_valid = 1'b0;
    rtx_h_count = '0;
    rtx_v_count = '0;
    force_redraw = 1'b0;
    cycle = 0;
    test_errs = 0;
    tests_passed = 0;
    tests_failed = 0;
    lfsr = 32'd92407;
    // memory powers up as zeros
    for (int i = 0; i < `RTX_MAX_NUM_OBJS; i++) begin
      exp_mem[i] = '0;
    end
    repeat (8) @(negedge clk_rtx);
    sys_rst = 1'b0;
    @(negedge clk_rtx);
    test_reset_defaults();
    test_camera_writes();
    test_count_bounce();
    test_object_memory();
    test_robustness();
    test_overwrite_latch();
    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== uart_flash/uart_memflash_rtx.sv ====
`include "rtx_settings.svh"

module uart_memflash_rtx
  import rtx_pkg::*;
(
  input  logic       clk_rtx,
  input  logic       sys_rst,
  input  logic       rx_valid,
  input  logic [7:0] rx_byte,
  flash_if.assembler flash
);

  localparam int OBJ_BYTES = $bits(obj_t) / 8;
  localparam int VEC_BYTES = $bits(vec3_t) / 8;
  // abort after this many clk_rtx cycles without a byte
  localparam int TIMEOUT_CYCLES = `RTX_FLASH_TIMEOUT_BITS * `RTX_CLKS_PER_BIT;
  localparam int TO_W = $clog2(TIMEOUT_CYCLES);

  asm_state_t     state;
  logic [3:0]     bytes_left;
  logic           drop_q;
  logic           wen_q;
  logic           active_q;
  logic [TO_W-1:0] timeout_cnt;
  flash_target_t  target_q;
  obj_idx_t       idx_q;
  flash_payload_t payload_q;

  // decode of a byte taken as command
  flash_target_t  cmd_target;
  logic [3:0]     cmd_len;
  logic           cmd_known;
  logic           cmd_drop;

  always_comb begin
    cmd_target = TGT_OBJ;
    cmd_len    = 4'(OBJ_BYTES);
    cmd_known  = 1'b1;
    // object index past the memory, bytes still eaten
    cmd_drop   = !rx_byte[7] && (rx_byte[6:0] >= 7'(`RTX_MAX_NUM_OBJS));
    if (rx_byte[7]) begin
      case (rx_byte[2:0])
        3'd0: cmd_target = TGT_CAM_ORIGIN;
        3'd1: cmd_target = TGT_CAM_FORWARD;
        3'd2: cmd_target = TGT_CAM_RIGHT;
        3'd3: cmd_target = TGT_CAM_UP;
        3'd4: cmd_target = TGT_NUM_OBJS;
        3'd5: cmd_target = TGT_MAX_BOUNCES;
        // 6 and 7 unknown
        default: cmd_known = 1'b0;
      endcase
      cmd_len = (rx_byte[2] == 1'b0) ? 4'(VEC_BYTES) : 4'd1;
    end
  end

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      state       <= ASM_IDLE;
      bytes_left  <= '0;
      drop_q      <= 1'b0;
      wen_q       <= 1'b0;
      active_q    <= 1'b0;
      timeout_cnt <= '0;
    end else begin
      wen_q <= 1'b0;
      // active falls the cycle after wen
      if (wen_q) begin
        active_q <= 1'b0;
      end
      case (state)
        ASM_IDLE: begin
          timeout_cnt <= '0;
          if (rx_valid && cmd_known) begin
            state      <= ASM_PAYLOAD;
            active_q   <= 1'b1;
            bytes_left <= cmd_len;
            drop_q     <= cmd_drop;
          end
        end
        ASM_PAYLOAD: begin
          if (rx_valid) begin
            timeout_cnt <= '0;
            bytes_left  <= bytes_left - 1'b1;
            if (bytes_left == 4'd1) begin
              state <= ASM_IDLE;
              wen_q <= !drop_q;
              // no wen coming, so close the packet now
              if (drop_q) begin
                active_q <= 1'b0;
              end
            end
          end else if (timeout_cnt == TO_W'(TIMEOUT_CYCLES - 1)) begin
            // host went quiet mid packet
            state    <= ASM_IDLE;
            active_q <= 1'b0;
          end else begin
            timeout_cnt <= timeout_cnt + 1'b1;
          end
        end
        default: state <= ASM_IDLE;
      endcase
    end
  end

  // decoded fields and payload shifter, msb byte first
  always_ff @(posedge clk_rtx) begin
    if (state == ASM_IDLE && rx_valid) begin
      target_q  <= cmd_target;
      idx_q     <= obj_idx_t'(rx_byte[6:0]);
      // clear so short payloads stay right aligned
      payload_q <= '0;
    end else if (state == ASM_PAYLOAD && rx_valid) begin
      payload_q <= {payload_q[$bits(flash_payload_t)-9:0], rx_byte};
    end
  end

  assign flash.wen     = wen_q;
  assign flash.active  = active_q;
  assign flash.target  = target_q;
  assign flash.idx     = idx_q;
  assign flash.payload = payload_q;

  // wen never escapes an open packet
  assert property (@(posedge clk_rtx) disable iff (sys_rst) flash.wen |-> flash.active);

endmodule

// ==== uart_flash/uart_receive.sv ====
`include "rtx_settings.svh"

module uart_receive
  import rtx_pkg::*;
#(
  parameter int CLKS_PER_BIT = `RTX_CLKS_PER_BIT
) (
  input  logic       clk_rtx,
  input  logic       sys_rst,
  input  logic       uart_rxd,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  // start bit is checked half a bit in, data and stop a full bit apart
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  logic             rxd_meta;
  logic             rxd_sync;
  rx_state_t        state;
  logic [CNT_W-1:0] bit_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift_q;
  logic             bit_tick;

  // two flop synchroniser, line idles high
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= uart_rxd;
      rxd_sync <= rxd_meta;
    end
  end

  // centre of a data or stop bit
  assign bit_tick = (bit_cnt == FULL_BIT);

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      state    <= RX_IDLE;
      bit_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          bit_cnt <= '0;
          bit_idx <= '0;
          // falling edge opens a start bit
          if (!rxd_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (bit_cnt == HALF_BIT) begin
            bit_cnt <= '0;
            // glitch shorter than half a bit, back to idle
            state   <= rxd_sync ? RX_IDLE : RX_DATA;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_tick) begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_tick) begin
            bit_cnt  <= '0;
            state    <= RX_IDLE;
            // framing error drops the byte silently
            rx_valid <= rxd_sync;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // data path, lsb first
  always_ff @(posedge clk_rtx) begin
    if (state == RX_DATA && bit_tick) begin
      shift_q <= {rxd_sync, shift_q[7:1]};
    end
    if (state == RX_STOP && bit_tick && rxd_sync) begin
      rx_byte <= shift_q;
    end
  end

  // a whole frame lies between two bytes
  assert property (@(posedge clk_rtx) disable iff (sys_rst) rx_valid |=> !rx_valid);

endmodule
